// ==== mipsPkg.sv ====
/*
  mips subset package
  word and field types, opcode, function and alu control codes
*/
package mipsPkg;

  // ====================
  // types
  // ====================

  // data word, instruction, register value, pc
  typedef logic [31:0] wordT;
  // register number
  typedef logic [4:0] regAddrT;
  // data memory word address
  typedef logic [6:0] memAddrT;
  // instruction fields
  typedef logic [5:0] opcodeT;
  typedef logic [5:0] funcT;
  // alu operation class from main decoder
  typedef logic [1:0] aluOpT;
  // alu control code
  typedef logic [3:0] aluCtrlT;

  // ====================
  // opcodes
  // ====================

  localparam opcodeT opR   = 6'b000000;
  localparam opcodeT opLw  = 6'b100011;
  localparam opcodeT opSw  = 6'b101011;
  localparam opcodeT opBeq = 6'b000100;
  localparam opcodeT opJ   = 6'b000010;
  localparam opcodeT opJal = 6'b000011;

  // ====================
  // function field
  // ====================

  localparam funcT fnAdd = 6'b100000;
  localparam funcT fnSub = 6'b100010;
  localparam funcT fnAnd = 6'b100100;
  localparam funcT fnOr  = 6'b100101;
  localparam funcT fnSlt = 6'b101010;
  localparam funcT fnJr  = 6'b001000;

  // alu operation classes
  localparam aluOpT aluOpMem    = 2'b00;
  localparam aluOpT aluOpBranch = 2'b01;
  localparam aluOpT aluOpFunc   = 2'b10;

  // alu control codes
  localparam aluCtrlT aluAnd  = 4'b0000;
  localparam aluCtrlT aluOr   = 4'b0001;
  localparam aluCtrlT aluAdd  = 4'b0010;
  localparam aluCtrlT aluSub  = 4'b0110;
  localparam aluCtrlT aluSlt  = 4'b0111;
  localparam aluCtrlT aluNone = 4'b1111;

  // jal link target
  localparam regAddrT linkReg = 5'd31;

endpackage

// ==== controlUnit.sv ====
/*
  main decoder
  opcode and function field to datapath control levels
*/
module controlUnit (
  input  mipsPkg::opcodeT opcode,
  input  mipsPkg::funcT   func,
  output logic            regDst,
  output logic            aluSrc,
  output logic            memToReg,
  output logic            regWrite,
  output logic            memRead,
  output logic            memWrite,
  output logic            branch,
  output logic            jump,
  output logic            link,
  output logic            jumpReg,
  output mipsPkg::aluOpT  aluOp
);
  import mipsPkg::*;

  always_comb begin
    // everything idle by default
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    jumpReg  = 1'b0;
    aluOp    = aluOpMem;
    case (opcode)
      opR: begin
        regDst  = 1'b1;
        aluOp   = aluOpFunc;
        // jr shares the R opcode but writes nothing
        jumpReg = (func == fnJr);
        regWrite = (func != fnJr);
      end
      opLw: begin
        // base plus immediate, data back to rt
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        memRead  = 1'b1;
        regWrite = 1'b1;
      end
      opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      opBeq: begin
        // compare by subtract
        branch = 1'b1;
        aluOp  = aluOpBranch;
      end
      opJ: jump = 1'b1;
      opJal: begin
        // pc plus 4 into r31
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: begin
        // unknown opcode acts as nop
      end
    endcase
  end

endmodule

// ==== aluControl.sv ====
/*
  alu control decoder
  operation class and function field to alu control code
*/
module aluControl (
  input  mipsPkg::aluOpT   aluOp,
  input  mipsPkg::funcT    func,
  output mipsPkg::aluCtrlT aluCtrl
);
  import mipsPkg::*;

  always_comb begin
    case (aluOp)
      // address calculation for lw and sw
      aluOpMem: aluCtrl = aluAdd;
      // beq compares through subtract
      aluOpBranch: aluCtrl = aluSub;
      aluOpFunc: begin
        // R-type, decode function field
        case (func)
          fnAdd:   aluCtrl = aluAdd;
          fnSub:   aluCtrl = aluSub;
          fnAnd:   aluCtrl = aluAnd;
          fnOr:    aluCtrl = aluOr;
          fnSlt:   aluCtrl = aluSlt;
          // jr and anything unsupported
          default: aluCtrl = aluNone;
        endcase
      end
      default: aluCtrl = aluNone;
    endcase
  end

endmodule

// ==== alu.sv ====
/*
  32-bit alu
  and, or, add, sub, unsigned slt with zero flag
*/
module alu (
  input  mipsPkg::wordT    a,
  input  mipsPkg::wordT    b,
  input  mipsPkg::aluCtrlT aluCtrl,
  output mipsPkg::wordT    result,
  output logic             zero
);
  import mipsPkg::*;

  // ====================
  // operation select
  // ====================

  always_comb begin
    case (aluCtrl)
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      aluAdd: result = a + b;
      aluSub: result = a - b;
      // unsigned compare
      aluSlt: begin
        result = '0;
        result[0] = (a < b);
      end
      // aluNone and undefined codes
      default: result = '0;
    endcase
  end

  // ====================
  // flags
  // ====================

  // high on any zero result
  // only meaningful to the core together with branch
  assign zero = (result == '0);

endmodule

// ==== registerFile.sv ====
/*
  32x32 register file
  two combinational read ports, one write port, r0 hard-wired to zero
*/
module registerFile (
  input  logic            clk,
  input  logic            rst,
  input  logic            writeEn,
  input  mipsPkg::regAddrT readAddr1,
  input  mipsPkg::regAddrT readAddr2,
  input  mipsPkg::regAddrT writeAddr,
  input  mipsPkg::wordT    writeData,
  output mipsPkg::wordT    readData1,
  output mipsPkg::wordT    readData2
);
  import mipsPkg::*;

  // register storage
  wordT regs [32];

  // ====================
  // write port
  // ====================

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // all registers cleared
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      // writes to r0 dropped
      regs[writeAddr] <= writeData;
    end
  end

  // ====================
  // read ports
  // ====================

  // r0 forced to zero
  assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
  assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

// ==== pcUnit.sv ====
/*
  program counter
  next address from sequential, branch, jump and jump-register paths
*/
module pcUnit (
  input  logic          clk,
  input  logic          rst,
  input  logic          jump,
  input  logic          jumpReg,
  input  logic          branchTaken,
  input  logic [25:0]   target,
  input  mipsPkg::wordT branchOffset,
  input  mipsPkg::wordT jumpRegAddr,
  output mipsPkg::wordT pc,
  output mipsPkg::wordT pcPlus4
);
  import mipsPkg::*;

  wordT pcReg;
  wordT nextPc;
  wordT branchTarget;
  wordT jumpTarget;

  // sequential address
  assign pcPlus4 = pcReg + 32'd4;

  // offset counts words
  assign branchTarget = pcPlus4 + {branchOffset[29:0], 2'b00};

  // pseudo-direct jump inside current 256MB region
  assign jumpTarget = {pcPlus4[31:28], target, 2'b00};

  // ====================
  // next pc select
  // ====================

  always_comb begin
    if (jump) begin
      nextPc = jumpTarget;
    end else if (branchTaken) begin
      nextPc = branchTarget;
    end else if (jumpReg) begin
      // full register value
      nextPc = jumpRegAddr;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // one update per instruction
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else begin
      pcReg <= nextPc;
    end
  end

  assign pc = pcReg;

endmodule

// ==== mipsCore.sv ====
/*
  single-cycle mips subset core
  field split, operand and write-back muxes, data memory strobes
*/
module mipsCore (
  input  logic             clk,
  input  logic             rst,
  input  mipsPkg::wordT    instr,
  output mipsPkg::wordT    instrAddr,
  input  mipsPkg::wordT    memReadData,
  output mipsPkg::memAddrT memAddr,
  output mipsPkg::wordT    memWriteData,
  output logic             memCen,
  output logic             memWen
);
  import mipsPkg::*;

  // ====================
  // instruction fields
  // ====================

  opcodeT  opcode;
  funcT    func;
  regAddrT rs;
  regAddrT rt;
  regAddrT rd;
  wordT    signExtImm;

  assign opcode = instr[31:26];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign func   = instr[5:0];
  // immediate sign-extended to word
  assign signExtImm = {{16{instr[15]}}, instr[15:0]};

  // control levels
  logic regDst, aluSrc, memToReg, regWrite;
  logic memRead, memWrite, branch, jump, link, jumpReg;
  aluOpT   aluOp;
  aluCtrlT aluCtrl;

  // datapath
  wordT    readData1, readData2;
  wordT    aluB, aluResult;
  logic    zero;
  regAddrT writeAddr;
  wordT    writeData;
  wordT    pc, pcPlus4;

  controlUnit uCtrl (
    .opcode  (opcode),
    .func    (func),
    .regDst  (regDst),
    .aluSrc  (aluSrc),
    .memToReg(memToReg),
    .regWrite(regWrite),
    .memRead (memRead),
    .memWrite(memWrite),
    .branch  (branch),
    .jump    (jump),
    .link    (link),
    .jumpReg (jumpReg),
    .aluOp   (aluOp)
  );

  aluControl uAluCtrl (.aluOp(aluOp), .func(func), .aluCtrl(aluCtrl));

  registerFile uRegs (
    .clk      (clk),
    .rst      (rst),
    .writeEn  (regWrite),
    .readAddr1(rs),
    .readAddr2(rt),
    .writeAddr(writeAddr),
    .writeData(writeData),
    .readData1(readData1),
    .readData2(readData2)
  );

  // second operand, register or immediate
  assign aluB = aluSrc ? signExtImm : readData2;

  alu uAlu (.a(readData1), .b(aluB), .aluCtrl(aluCtrl), .result(aluResult), .zero(zero));

  pcUnit uPc (
    .clk         (clk),
    .rst         (rst),
    .jump        (jump),
    .jumpReg     (jumpReg),
    // beq taken only when subtract gives zero
    .branchTaken (branch & zero),
    .target      (instr[25:0]),
    .branchOffset(signExtImm),
    .jumpRegAddr (readData1),
    .pc          (pc),
    .pcPlus4     (pcPlus4)
  );

  // ====================
  // write-back
  // ====================

  // rd for R-type, rt otherwise, r31 for jal
  assign writeAddr = link ? linkReg : (regDst ? rd : rt);
  // return address, load data or alu result
  assign writeData = link ? pcPlus4 : (memToReg ? memReadData : aluResult);

  // ====================
  // memory ports
  // ====================

  assign instrAddr    = pc;
  // word address from byte address
  assign memAddr      = aluResult[8:2];
  assign memWriteData = readData2;
  // strobes active low
  assign memCen       = ~(memRead | memWrite);
  assign memWen       = ~memWrite;

endmodule

// ==== mipsTbMem.sv ====
/*
  testbench memories
  instruction rom with self-jump fill, data ram with a log of all stores
*/
module mipsTbMem (
  input  logic             clk,
  input  mipsPkg::wordT    instrAddr,
  output mipsPkg::wordT    instr,
  input  mipsPkg::memAddrT memAddr,
  input  mipsPkg::wordT    memWriteData,
  output mipsPkg::wordT    memReadData,
  input  logic             memCen,
  input  logic             memWen
);
  import mipsPkg::*;

  localparam int romWords = 256;
  localparam int ramWords = 128;
  localparam int logDepth = 64;

  wordT    rom [romWords];
  wordT    ram [ramWords];
  // store log, in program order
  memAddrT logAddr [logDepth];
  wordT    logData [logDepth];
  int      logCount;

  // ====================
  // read ports
  // ====================

  // word index from byte address
  assign instr       = rom[instrAddr[9:2]];
  assign memReadData = ram[memAddr];

  // write on rising edge, both strobes low
  always @(posedge clk) begin
    if (!memCen && !memWen) begin
      ram[memAddr] <= memWriteData;
      if (logCount < logDepth) begin
        logAddr[logCount] <= memAddr;
        logData[logCount] <= memWriteData;
      end
      logCount <= logCount + 1;
    end
  end

  // every rom word jumps to itself, so a stray jump halts
  task clearAll;
    for (int i = 0; i < romWords; i++) begin
      rom[i] = {opJ, 26'(i)};
    end
    // fill tagged with the word address
    for (int i = 0; i < ramWords; i++) begin
      ram[i] = 32'hdead_0000 + i;
    end
    logCount = 0;
  endtask

endmodule

// ==== mipsTb.sv ====
/*
  mips core testbench
  directed programs per test, results checked through the logged stores
*/
module mipsTb;
  import mipsPkg::*;

  localparam int resetCycles   = 4;
  localparam int timeoutMargin = 64;

  logic    clk;
  logic    rst;
  wordT    instr;
  wordT    instrAddr;
  wordT    memReadData;
  wordT    memWriteData;
  memAddrT memAddr;
  logic    memCen;
  logic    memWen;

  string  testName;
  int     progLen;
  int     timeoutLimit;
  int     cycles;
  int     checks;
  int     valueErrors;
  int     otherErrors;
  integer seed;

  mipsCore UUT (
    .clk(clk), .rst(rst), .instr(instr), .instrAddr(instrAddr),
    .memReadData(memReadData), .memAddr(memAddr), .memWriteData(memWriteData),
    .memCen(memCen), .memWen(memWen)
  );

  mipsTbMem tbMem (
    .clk(clk), .instrAddr(instrAddr), .instr(instr), .memAddr(memAddr),
    .memWriteData(memWriteData), .memReadData(memReadData),
    .memCen(memCen), .memWen(memWen)
  );

  always #2 clk = ~clk;

  // limit grows with every loaded instruction and reset
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > timeoutLimit) begin
      $display("timeout in test %s, no halt after %0d cycles", testName, cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  // ====================
  // compare tasks
  // ====================

  task automatic checkWord(string what, wordT exp, wordT act);
    checks++;
    if (act !== exp) begin
      valueErrors++;
      $display("[ERROR] %s %s: expected %h, actual %h", testName, what, exp, act);
    end
  endtask

  task automatic checkAddr(string what, memAddrT exp, memAddrT act);
    checks++;
    if (act !== exp) begin
      valueErrors++;
      $display("[ERROR] %s %s: expected %h, actual %h", testName, what, exp, act);
    end
  endtask

  task automatic checkLevel(string what, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      valueErrors++;
      $display("[ERROR] %s %s: expected %b, actual %b", testName, what, exp, act);
    end
  endtask

  // ====================
  // program assembly
  // ====================

  function automatic wordT encodeR(regAddrT rs, regAddrT rt, regAddrT rd, funcT fn);
    return {opR, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic wordT encodeI(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic wordT encodeJ(opcodeT op, logic [25:0] index);
    return {op, index};
  endfunction

  function automatic wordT signExtend(logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  // byte address to data word address
  function automatic memAddrT wordAddr(wordT byteAddr);
    return byteAddr[8:2];
  endfunction

  task automatic appendInstr(wordT w);
    tbMem.rom[progLen] = w;
    progLen++;
    timeoutLimit++;
  endtask

  // final self-jump ends the program
  task automatic appendHalt;
    appendInstr(encodeJ(opJ, 26'(progLen)));
  endtask

  // ====================
  // run control
  // ====================

  // core held in reset while memories are reloaded
  task automatic enterReset;
    @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    tbMem.clearAll();
    progLen = 0;
    timeoutLimit += resetCycles + 4;
  endtask

  task automatic releaseReset;
    repeat (resetCycles - 1) @(posedge clk);
    rst <= 1'b1;
  endtask

  task automatic runToSelfJump;
    do begin
      @(negedge clk);
    end while (instr !== encodeJ(opJ, instrAddr[27:2]));
  endtask

  task automatic checkStore(int idx, memAddrT expAddr, wordT expData);
    if (idx >= tbMem.logCount) begin
      otherErrors++;
      $display("%s: store %0d never happened", testName, idx);
    end else begin
      checkAddr($sformatf("store %0d address", idx), expAddr, tbMem.logAddr[idx]);
      checkWord($sformatf("store %0d data", idx), expData, tbMem.logData[idx]);
    end
  endtask

  task automatic checkStoreCount(int exp);
    checks++;
    if (tbMem.logCount != exp) begin
      valueErrors++;
      $display("[ERROR] %s store count: expected %0d, actual %0d", testName, exp, tbMem.logCount);
    end
  endtask

  // ====================
  // tests
  // ====================

  // five R-type ops on ram words 0 and 1, results to words 2..6
  task automatic runAluPair(string name, wordT a, wordT b);
    testName = name;
    enterReset();
    tbMem.ram[0] = a;
    tbMem.ram[1] = b;
    appendInstr(encodeR(0, 0, 9, fnOr));
    appendInstr(encodeI(opLw, 0, 1, 16'h0000));
    appendInstr(encodeI(opLw, 0, 2, 16'h0004));
    appendInstr(encodeR(1, 2, 3, fnAdd));
    appendInstr(encodeR(1, 2, 4, fnSub));
    appendInstr(encodeR(1, 2, 5, fnAnd));
    appendInstr(encodeR(1, 2, 6, fnOr));
    appendInstr(encodeR(1, 2, 7, fnSlt));
    for (int r = 3; r <= 7; r++) begin
      appendInstr(encodeI(opSw, 0, regAddrT'(r), 16'(4 * (r - 1))));
    end
    appendHalt();
    releaseReset();
    runToSelfJump();
    checkStore(0, 7'd2, a + b);
    checkStore(1, 7'd3, a - b);
    checkStore(2, 7'd4, a & b);
    checkStore(3, 7'd5, a | b);
    // slt compares unsigned
    checkStore(4, 7'd6, (a < b) ? 32'd1 : 32'd0);
    checkStoreCount(5);
  endtask

  task automatic loadStoreTest;
    wordT base;
    wordT valA;
    wordT valB;
    base = 32'h0000_0380;
    valA = 32'hcafe_0123;
    valB = 32'h8000_7ffe;
    testName = "loadStore";
    enterReset();
    // pointer at byte 0x50, operands around it
    // base has bits above 8 set, all address bits in use
    tbMem.ram[20] = base;
    tbMem.ram[wordAddr(base + signExtend(16'h0020))] = valA;
    tbMem.ram[wordAddr(base + signExtend(16'hfff0))] = valB;
    appendInstr(encodeR(0, 0, 9, fnOr));
    appendInstr(encodeI(opLw, 0, 1, 16'h0050));
    appendInstr(encodeI(opLw, 1, 2, 16'h0020));
    appendInstr(encodeI(opLw, 1, 3, 16'hfff0));
    appendInstr(encodeI(opSw, 1, 2, 16'hfff8));
    appendInstr(encodeI(opSw, 1, 3, 16'h0030));
    appendHalt();
    releaseReset();
    runToSelfJump();
    checkStore(0, wordAddr(base + signExtend(16'hfff8)), valA);
    checkStore(1, wordAddr(base + signExtend(16'h0030)), valB);
    checkStoreCount(2);
  endtask

  task automatic branchTest;
    testName = "branch";
    enterReset();
    tbMem.ram[0] = 32'd5;
    tbMem.ram[1] = 32'd5;
    tbMem.ram[2] = 32'd7;
    tbMem.ram[3] = 32'h1111_aaaa;
    tbMem.ram[4] = 32'h2222_bbbb;
    appendInstr(encodeR(0, 0, 9, fnOr));
    appendInstr(encodeI(opLw, 0, 1, 16'h0000));
    appendInstr(encodeI(opLw, 0, 2, 16'h0004));
    appendInstr(encodeI(opLw, 0, 3, 16'h0008));
    appendInstr(encodeI(opLw, 0, 4, 16'h000c));
    appendInstr(encodeI(opLw, 0, 5, 16'h0010));
    // 5 vs 7, falls through to the store
    appendInstr(encodeI(opBeq, 1, 3, 16'h0001));
    appendInstr(encodeI(opSw, 0, 4, 16'h0040));
    // 5 vs 5, skips the next store
    appendInstr(encodeI(opBeq, 1, 2, 16'h0001));
    appendInstr(encodeI(opSw, 0, 5, 16'h0044));
    appendInstr(encodeI(opSw, 0, 5, 16'h0048));
    appendHalt();
    releaseReset();
    runToSelfJump();
    checkStore(0, 7'd16, 32'h1111_aaaa);
    checkStore(1, 7'd18, 32'h2222_bbbb);
    checkStoreCount(2);
  endtask

  task automatic jumpTest;
    testName = "jump";
    enterReset();
    tbMem.ram[0] = 32'h5a5a_0f0f;
    appendInstr(encodeR(0, 0, 9, fnOr));
    appendInstr(encodeI(opLw, 0, 4, 16'h0000));
    appendInstr(encodeJ(opJ, 26'd7));
    appendInstr(encodeI(opSw, 0, 4, 16'h004c));
    // subroutine at word 4
    appendInstr(encodeI(opSw, 0, 4, 16'h0048));
    appendInstr(encodeR(31, 0, 0, fnJr));
    appendHalt();
    // call at word 7, return address 32 needs more than 5 bits
    appendInstr(encodeJ(opJal, 26'd4));
    appendInstr(encodeI(opSw, 0, 31, 16'h0044));
    appendHalt();
    releaseReset();
    runToSelfJump();
    checkStore(0, 7'd18, 32'h5a5a_0f0f);
    checkStore(1, 7'd17, 32'd7 * 4 + 32'd4);
    checkStoreCount(2);
  endtask

  // r7 still holds slt result from earlier tests until reset
  task automatic zeroRegTest;
    testName = "zeroReg";
    enterReset();
    tbMem.ram[0] = 32'h1111_2222;
    tbMem.ram[1] = 32'h0bad_f00d;
    appendInstr(encodeR(0, 0, 9, fnOr));
    appendInstr(encodeI(opLw, 0, 0, 16'h0000));
    appendInstr(encodeI(opLw, 0, 1, 16'h0004));
    appendInstr(encodeR(1, 1, 0, fnAdd));
    appendInstr(encodeI(opSw, 0, 0, 16'h0040));
    appendInstr(encodeI(opSw, 0, 7, 16'h0044));
    appendInstr(encodeI(opSw, 0, 1, 16'h0048));
    appendHalt();
    releaseReset();
    @(negedge clk);
    checkWord("pc after reset", 32'd0, instrAddr);
    checkLevel("memCen idle", 1'b1, memCen);
    checkLevel("memWen idle", 1'b1, memWen);
    // first lw
    @(negedge clk);
    checkLevel("memCen on lw", 1'b0, memCen);
    checkLevel("memWen on lw", 1'b1, memWen);
    runToSelfJump();
    checkStore(0, 7'd16, 32'd0);
    checkStore(1, 7'd17, 32'd0);
    checkStore(2, 7'd18, 32'h0bad_f00d);
    checkStoreCount(3);
  endtask

  task automatic randomTest;
    wordT a;
    wordT b;
    for (int k = 0; k < 4; k++) begin
      a = $random(seed);
      b = $random(seed);
      runAluPair($sformatf("random%0d", k), a, b);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    seed = 32'h9885ab18;
    cycles = 0;
    checks = 0;
    valueErrors = 0;
    otherErrors = 0;
    progLen = 0;
    timeoutLimit = timeoutMargin;
    testName = "init";
    tbMem.clearAll();
    runAluPair("arith", 32'h0000_1234, 32'hffff_0f0f);
    loadStoreTest();
    branchTest();
    jumpTest();
    zeroRegTest();
    randomTest();
    $display("%0d checks, %0d value errors, %0d other errors", checks, valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
mipsPkg.sv
controlUnit.sv
aluControl.sv
alu.sv
registerFile.sv
pcUnit.sv
mipsCore.sv
mipsTbMem.sv
mipsTb.sv

// ==== Bender.yml ====
package:
  name: mipsCore

sources:
  - mipsPkg.sv
  - controlUnit.sv
  - aluControl.sv
  - alu.sv
  - registerFile.sv
  - pcUnit.sv
  - mipsCore.sv
  - target: simulation
    files:
      - mipsTbMem.sv
      - mipsTb.sv
